//--- hw/mem_subsys_defines.svh
// Sizes, region bits and memory port widths shared by the memory subsystem RTL and bench.
`ifndef MEM_SUBSYS_DEFINES_SVH
`define MEM_SUBSYS_DEFINES_SVH

// External memory port.
`define MEM_AW 32
`define MEM_DW 32
`define MEM_SW (`MEM_DW / 8)  // One strobe bit per byte.

// Instruction cache, one word per line.
`define ICACHE_LINES 16

// One-hot region select bits of the data bus address.
// Data memory wins over the timer when both bits are set.
`define REGION_DMEM_BIT  30
`define REGION_TIMER_BIT 28

// Byte offset bits inside a word.
`define WORD_OFS_W 2

`endif

//--- hw/mem_subsys_pkg.sv
// Request and response structs shared by the core ports, the cache, the data port and the arbiter.
`include "mem_subsys_defines.svh"

package mem_subsys_pkg;

    // One word transfer toward external memory. Zero strobe is a read.
    typedef struct packed {
        logic [`MEM_AW-1:0] addr;
        logic [`MEM_DW-1:0] wdata;
        logic [`MEM_SW-1:0] wstrb;
    } mem_req_t;

    // Core data bus access, held stable while stalled.
    typedef struct packed {
        logic               sel;
        logic               we;
        logic [`MEM_SW-1:0] mask;
        logic [`MEM_AW-1:0] addr;
        logic [`MEM_DW-1:0] wdata;
    } dbus_req_t;

    // Arbiter answer with a single cycle done pulse.
    typedef struct packed {
        logic               done;
        logic [`MEM_DW-1:0] rdata;
    } mem_rsp_t;

endpackage

//--- hw/icache.sv
// Direct-mapped one-word-line instruction cache; stalls fetch on a miss and refills via the arbiter.
`timescale 1ns/1ps
`include "mem_subsys_defines.svh"

module icache (
    input  logic                    clk_i,
    input  logic                    rst_n_i,

    input  logic [`MEM_AW-1:0]      ifetch_addr_i,
    output logic [`MEM_DW-1:0]      ifetch_data_o,
    output logic                    ifetch_stall_o,

    output logic                    fill_req_o,
    output mem_subsys_pkg::mem_req_t fill_req_o_data,
    input  mem_subsys_pkg::mem_rsp_t fill_rsp_i
);

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = `MEM_AW - IDX_W - `WORD_OFS_W;

    logic [IDX_W-1:0] idx;
    logic [TAG_W-1:0] tag;
    logic             hit;

    logic [`ICACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]         tag_mem  [`ICACHE_LINES];
    logic [`MEM_DW-1:0]       data_mem [`ICACHE_LINES];

    // Word address split into index and tag.
    assign idx = ifetch_addr_i[`WORD_OFS_W +: IDX_W];
    assign tag = ifetch_addr_i[`MEM_AW-1 -: TAG_W];

    // Lookup is purely combinational.
    assign hit = valid_q[idx] && (tag_mem[idx] == tag);

    assign ifetch_data_o  = data_mem[idx];
    assign ifetch_stall_o = !hit;

    // A miss asks for the missing word and keeps asking until done.
    assign fill_req_o            = !hit;
    assign fill_req_o_data.addr  = {ifetch_addr_i[`MEM_AW-1:`WORD_OFS_W], {`WORD_OFS_W{1'b0}}};
    assign fill_req_o_data.wdata = '0;
    assign fill_req_o_data.wstrb = '0;  // Read only.

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_rsp_i.done) begin
            valid_q[idx] <= 1'b1;
        end
    end

    // Tag and data arrays.
    always_ff @(posedge clk_i) begin
        if (fill_rsp_i.done) begin
            tag_mem[idx]  <= tag;
            data_mem[idx] <= fill_rsp_i.rdata;  // Hits next cycle.
        end
    end

endmodule

//--- hw/data_port.sv
// Data bus front end; decodes the memory and timer regions and holds the free-running timer.
`timescale 1ns/1ps
`include "mem_subsys_defines.svh"

module data_port (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  mem_subsys_pkg::dbus_req_t dbus_req_i,
    output logic [`MEM_DW-1:0]       dbus_rdata_o,
    output logic                     dbus_stall_o,

    output logic                     dmem_req_o,
    output mem_subsys_pkg::mem_req_t dmem_req_o_data,
    input  mem_subsys_pkg::mem_rsp_t dmem_rsp_i
);

    logic               in_dmem;
    logic               in_timer;
    logic               sel_dmem;
    logic               sel_timer;
    logic               done_q;
    logic [`MEM_DW-1:0] rdata_q;
    logic [`MEM_DW-1:0] timer_q;
    logic [`MEM_DW-1:0] timer_wr;

    // Memory region has priority over the timer.
    assign in_dmem   = dbus_req_i.addr[`REGION_DMEM_BIT];
    assign in_timer  = !in_dmem && dbus_req_i.addr[`REGION_TIMER_BIT];
    assign sel_dmem  = dbus_req_i.sel && in_dmem;
    assign sel_timer = dbus_req_i.sel && in_timer;

    // done_q marks the completion cycle, when the request is still on the bus.
    assign dmem_req_o   = sel_dmem && !done_q;
    assign dbus_stall_o = sel_dmem && !done_q;

    assign dmem_req_o_data.addr  = dbus_req_i.addr;
    assign dmem_req_o_data.wdata = dbus_req_i.wdata;
    assign dmem_req_o_data.wstrb = dbus_req_i.we ? dbus_req_i.mask : '0;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= dmem_rsp_i.done;
        end
    end

    always_ff @(posedge clk_i) begin
        if (dmem_rsp_i.done) begin
            rdata_q <= dmem_rsp_i.rdata;
        end
    end

    always_comb begin
        if (in_dmem) begin
            dbus_rdata_o = dmem_rsp_i.done ? dmem_rsp_i.rdata : rdata_q;
        end else if (in_timer) begin
            dbus_rdata_o = timer_q;  // Zero wait.
        end else begin
            dbus_rdata_o = '0;
        end
    end

    // Byte merge for a timer load.
    always_comb begin
        for (int i = 0; i < `MEM_SW; i++) begin
            timer_wr[8*i +: 8] = dbus_req_i.mask[i] ? dbus_req_i.wdata[8*i +: 8]
                                                    : timer_q[8*i +: 8];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            timer_q <= '0;
        end else if (sel_timer && dbus_req_i.we) begin
            timer_q <= timer_wr;  // Counts on from here next cycle.
        end else begin
            timer_q <= timer_q + 1'b1;
        end
    end

endmodule

//--- hw/mem_arbiter.sv
// Grants the single external memory port to the data or instruction side and routes the answer back.
`timescale 1ns/1ps
`include "mem_subsys_defines.svh"

module mem_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_n_i,

    input  logic                     ireq_i,
    input  mem_subsys_pkg::mem_req_t ireq_data_i,
    output mem_subsys_pkg::mem_rsp_t irsp_o,

    input  logic                     dreq_i,
    input  mem_subsys_pkg::mem_req_t dreq_data_i,
    output mem_subsys_pkg::mem_rsp_t drsp_o,

    output logic                     mem_valid_o,
    input  logic                     mem_ready_i,
    output logic [`MEM_SW-1:0]       mem_wstrb_o,
    output logic [`MEM_AW-1:0]       mem_addr_o,
    output logic [`MEM_DW-1:0]       mem_wdata_o,
    input  logic [`MEM_DW-1:0]       mem_rdata_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DBUSY,
        ST_IBUSY
    } state_t;

    state_t                   state_q;
    state_t                   state_d;
    mem_subsys_pkg::mem_req_t grant_req;
    mem_subsys_pkg::mem_req_t req_q;

    // Data side first.
    assign grant_req = dreq_i ? dreq_data_i : ireq_data_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (dreq_i) begin
                    state_d = ST_DBUSY;
                end else if (ireq_i) begin
                    state_d = ST_IBUSY;
                end
            end
            ST_DBUSY, ST_IBUSY: begin
                if (mem_ready_i) begin
                    state_d = ST_IDLE;  // Transfer happens this cycle.
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= ST_IDLE;
            mem_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_valid_o <= (state_d != ST_IDLE);
        end
    end

    // Request fields only load while idle, so they hold for the whole wait.
    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE) begin
            req_q <= grant_req;
        end
    end

    assign mem_addr_o  = req_q.addr;
    assign mem_wdata_o = req_q.wdata;
    assign mem_wstrb_o = req_q.wstrb;

    // Busy implies valid, so ready alone ends the transfer.
    assign drsp_o.done  = (state_q == ST_DBUSY) && mem_ready_i;
    assign drsp_o.rdata = mem_rdata_i;
    assign irsp_o.done  = (state_q == ST_IBUSY) && mem_ready_i;
    assign irsp_o.rdata = mem_rdata_i;

endmodule

//--- hw/mem_subsys.sv
// Memory subsystem top; joins the instruction cache, data port and arbiter to the outside ports.
`timescale 1ns/1ps
`include "mem_subsys_defines.svh"

module mem_subsys (
    input  logic                      clk_i,
    input  logic                      rst_n_i,

    input  logic [`MEM_AW-1:0]        ifetch_addr_i,
    output logic [`MEM_DW-1:0]        ifetch_data_o,
    output logic                      ifetch_stall_o,

    input  mem_subsys_pkg::dbus_req_t dbus_req_i,
    output logic [`MEM_DW-1:0]        dbus_rdata_o,
    output logic                      dbus_stall_o,

    output logic                      mem_valid_o,
    input  logic                      mem_ready_i,
    output logic [`MEM_SW-1:0]        mem_wstrb_o,
    output logic [`MEM_AW-1:0]        mem_addr_o,
    output logic [`MEM_DW-1:0]        mem_wdata_o,
    input  logic [`MEM_DW-1:0]        mem_rdata_i
);

    logic                     ireq;
    mem_subsys_pkg::mem_req_t ireq_data;
    mem_subsys_pkg::mem_rsp_t irsp;

    logic                     dreq;
    mem_subsys_pkg::mem_req_t dreq_data;
    mem_subsys_pkg::mem_rsp_t drsp;

    icache i_icache (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .ifetch_addr_i   (ifetch_addr_i),
        .ifetch_data_o   (ifetch_data_o),
        .ifetch_stall_o  (ifetch_stall_o),
        .fill_req_o      (ireq),
        .fill_req_o_data (ireq_data),
        .fill_rsp_i      (irsp)
    );

    data_port i_data_port (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .dbus_req_i      (dbus_req_i),
        .dbus_rdata_o    (dbus_rdata_o),
        .dbus_stall_o    (dbus_stall_o),
        .dmem_req_o      (dreq),
        .dmem_req_o_data (dreq_data),
        .dmem_rsp_i      (drsp)
    );

    mem_arbiter i_mem_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .ireq_i      (ireq),
        .ireq_data_i (ireq_data),
        .irsp_o      (irsp),
        .dreq_i      (dreq),
        .dreq_data_i (dreq_data),
        .drsp_o      (drsp),
        .mem_valid_o (mem_valid_o),
        .mem_ready_i (mem_ready_i),
        .mem_wstrb_o (mem_wstrb_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o),
        .mem_rdata_i (mem_rdata_i)
    );

endmodule

//--- bench/mem_subsys_props.sv
// Concurrent assertions on the external memory port, bound into every mem_arbiter instance.
`timescale 1ns/1ps
`include "mem_subsys_defines.svh"

module mem_subsys_props (
    input logic                     clk_i,
    input logic                     rst_n_i,
    input logic                     mem_valid_i,
    input logic                     mem_ready_i,
    input logic [`MEM_SW-1:0]       mem_wstrb_i,
    input logic [`MEM_AW-1:0]       mem_addr_i,
    input logic [`MEM_DW-1:0]       mem_wdata_i,
    input mem_subsys_pkg::mem_rsp_t irsp_i,
    input mem_subsys_pkg::mem_rsp_t drsp_i
);

    valid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_valid_i && !mem_ready_i |=> mem_valid_i)
        else $error("mem_valid_o fell before mem_ready_i");

    // Address, data and strobe frozen while the memory waits.
    fields_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_valid_i && !mem_ready_i |=>
            $stable(mem_addr_i) && $stable(mem_wdata_i) && $stable(mem_wstrb_i))
        else $error("memory request changed while waiting for mem_ready_i");

    valid_low_in_reset: assert property (@(posedge clk_i) !rst_n_i |=> !mem_valid_i)
        else $error("mem_valid_o high after a reset cycle");

    one_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(irsp_i.done && drsp_i.done))
        else $error("done raised toward both requesters");

endmodule

bind mem_arbiter mem_subsys_props i_props (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_valid_i (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_wstrb_i (mem_wstrb_o),
    .mem_addr_i  (mem_addr_o),
    .mem_wdata_i (mem_wdata_o),
    .irsp_i      (irsp_o),
    .drsp_i      (drsp_o)
);

//--- bench/mem_subsys_checker.sv
// Scoreboard; models memory, cache tags and the timer from the port traffic and checks each access.
`timescale 1ns/1ps
`include "mem_subsys_defines.svh"

module mem_subsys_checker (
    input  logic                      clk_i,
    input  logic                      rst_n_i,
    input  logic [`MEM_AW-1:0]        ifetch_addr_i,
    input  logic [`MEM_DW-1:0]        ifetch_data_i,
    input  logic                      ifetch_stall_i,
    input  mem_subsys_pkg::dbus_req_t dbus_req_i,
    input  logic [`MEM_DW-1:0]        dbus_rdata_i,
    input  logic                      dbus_stall_i,
    input  logic                      mem_valid_i,
    input  logic                      mem_ready_i,
    input  logic                      final_i,
    output int                        errors_o,
    output int                        checks_o
);

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    localparam int WA_W  = `MEM_AW - `WORD_OFS_W;
    localparam int TAG_W = WA_W - IDX_W;

    logic [`MEM_DW-1:0]       model_mem [logic [WA_W-1:0]];
    logic [`ICACHE_LINES-1:0] tag_valid;
    logic [TAG_W-1:0]         tags [`ICACHE_LINES];
    logic [`MEM_DW-1:0]       timer;
    logic                     fetch_new;
    logic                     final_done;
    int                       xfers;
    int                       expected_xfers;
    int                       errors = 0;
    int                       checks = 0;

    assign errors_o = errors;
    assign checks_o = checks;

    function automatic logic [`MEM_DW-1:0] initial_word(input logic [WA_W-1:0] waddr);
        return {waddr[13:0], 2'b01, waddr[29:14]} ^ 32'h6b3d_91c7;
    endfunction

    function automatic logic [`MEM_DW-1:0] model_word(input logic [WA_W-1:0] waddr);
        if (model_mem.exists(waddr)) begin
            return model_mem[waddr];
        end
        return initial_word(waddr);
    endfunction

    function automatic logic [`MEM_DW-1:0] merge_bytes(input logic [`MEM_DW-1:0] cur,
            input logic [`MEM_DW-1:0] wdata, input logic [`MEM_SW-1:0] mask);
        logic [`MEM_DW-1:0] res;
        res = cur;
        for (int b = 0; b < `MEM_SW; b++) begin
            if (mask[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic check_word(input string name, input logic [`MEM_DW-1:0] exp,
            input logic [`MEM_DW-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    always @(posedge clk_i) begin : scoreboard
        logic [WA_W-1:0]  faddr;
        logic [WA_W-1:0]  daddr;
        logic [IDX_W-1:0] idx;
        logic [TAG_W-1:0] tag;
        logic             is_dmem;
        logic             is_timer;
        faddr    = ifetch_addr_i[`MEM_AW-1:`WORD_OFS_W];
        daddr    = dbus_req_i.addr[`MEM_AW-1:`WORD_OFS_W];
        idx      = faddr[IDX_W-1:0];
        tag      = faddr[WA_W-1 -: TAG_W];
        is_dmem  = dbus_req_i.addr[`REGION_DMEM_BIT];
        is_timer = !is_dmem && dbus_req_i.addr[`REGION_TIMER_BIT];
        if (!rst_n_i) begin
            tag_valid      = '0;
            timer          = '0;
            fetch_new      = 1'b1;
            final_done     = 1'b0;
            xfers          = 0;
            expected_xfers = 0;
        end else begin
            // A new fetch that misses the tag copy costs one memory read.
            if (fetch_new && !(tag_valid[idx] && tags[idx] == tag)) begin
                expected_xfers++;
            end
            fetch_new = !ifetch_stall_i;
            if (!ifetch_stall_i) begin
                check_word("ifetch_data_o", model_word(faddr), ifetch_data_i);
                tag_valid[idx] = 1'b1;
                tags[idx]      = tag;
            end
            if (dbus_req_i.sel && is_dmem && !dbus_stall_i) begin
                expected_xfers++;
                if (dbus_req_i.we) begin
                    model_mem[daddr] = merge_bytes(model_word(daddr), dbus_req_i.wdata,
                                                   dbus_req_i.mask);
                end else begin
                    check_word("dbus_rdata_o", model_word(daddr), dbus_rdata_i);
                end
            end else if (dbus_req_i.sel && !is_dmem) begin
                checks++;
                if (dbus_stall_i) begin
                    errors++;
                    $display("Error at %0t: access to %h stalled instead of completing at once",
                             $time, dbus_req_i.addr);
                end
                if (!dbus_req_i.we) begin
                    check_word("dbus_rdata_o", is_timer ? timer : '0, dbus_rdata_i);
                end
            end
            if (dbus_req_i.sel && is_timer && dbus_req_i.we) begin
                timer = merge_bytes(timer, dbus_req_i.wdata, dbus_req_i.mask);
            end else begin
                timer = timer + 32'd1;
            end
            if (mem_valid_i && mem_ready_i) begin
                xfers++;
            end
            if (final_i && !final_done) begin
                final_done = 1'b1;
                checks++;
                if (xfers != expected_xfers) begin
                    errors++;
                    $display("Error: memory port made %0d transfers where %0d were expected",
                             xfers, expected_xfers);
                end
            end
        end
    end

endmodule

//--- bench/mem_subsys_tb.sv
// Testbench top; plays the core on both ports and the external memory with random ready latency.
`timescale 1ns/1ps
`include "mem_subsys_defines.svh"

module mem_subsys_tb;

    localparam int          N_FETCH = 400;
    localparam int          N_DATA  = 300;
    localparam int          TIMEOUT = 64;
    localparam logic [31:0] IBASE   = 32'h0000_1000;
    localparam logic [31:0] DBASE   = 32'h4000_0000;
    localparam logic [31:0] TBASE   = 32'h1000_0000;
    localparam logic [31:0] NBASE   = 32'h0000_8000;  // Neither region bit.

    logic                      clk;
    logic                      rst_n;
    logic [`MEM_AW-1:0]        ifetch_addr;
    logic [`MEM_DW-1:0]        ifetch_data;
    logic                      ifetch_stall;
    mem_subsys_pkg::dbus_req_t dbus_req;
    logic [`MEM_DW-1:0]        dbus_rdata;
    logic                      dbus_stall;
    logic                      mem_valid;
    logic                      mem_ready;
    logic [`MEM_SW-1:0]        mem_wstrb;
    logic [`MEM_AW-1:0]        mem_addr;
    logic [`MEM_DW-1:0]        mem_wdata;
    logic [`MEM_DW-1:0]        mem_rdata;
    logic                      final_check;
    int                        errors;
    int                        checks;
    int                        seed = 93;

    logic [`MEM_DW-1:0] ext_mem [logic [`MEM_AW-`WORD_OFS_W-1:0]];

    mem_subsys i_dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .ifetch_addr_i  (ifetch_addr),
        .ifetch_data_o  (ifetch_data),
        .ifetch_stall_o (ifetch_stall),
        .dbus_req_i     (dbus_req),
        .dbus_rdata_o   (dbus_rdata),
        .dbus_stall_o   (dbus_stall),
        .mem_valid_o    (mem_valid),
        .mem_ready_i    (mem_ready),
        .mem_wstrb_o    (mem_wstrb),
        .mem_addr_o     (mem_addr),
        .mem_wdata_o    (mem_wdata),
        .mem_rdata_i    (mem_rdata)
    );

    mem_subsys_checker i_checker (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .ifetch_addr_i  (ifetch_addr),
        .ifetch_data_i  (ifetch_data),
        .ifetch_stall_i (ifetch_stall),
        .dbus_req_i     (dbus_req),
        .dbus_rdata_i   (dbus_rdata),
        .dbus_stall_i   (dbus_stall),
        .mem_valid_i    (mem_valid),
        .mem_ready_i    (mem_ready),
        .final_i        (final_check),
        .errors_o       (errors),
        .checks_o       (checks)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Rotated and scrambled word address, so every word differs.
    function automatic logic [`MEM_DW-1:0] initial_word(input logic [29:0] waddr);
        return {waddr[13:0], 2'b01, waddr[29:14]} ^ 32'h6b3d_91c7;
    endfunction

    function automatic logic [`MEM_DW-1:0] read_mem(input logic [`MEM_AW-1:0] addr);
        if (ext_mem.exists(addr[`MEM_AW-1:`WORD_OFS_W])) begin
            return ext_mem[addr[`MEM_AW-1:`WORD_OFS_W]];
        end
        return initial_word(addr[`MEM_AW-1:`WORD_OFS_W]);
    endfunction

    function automatic mem_subsys_pkg::dbus_req_t random_data_req();
        mem_subsys_pkg::dbus_req_t req;
        logic [31:0]               rnd;
        logic [31:0]               base;
        rnd = $random(seed);
        case (rnd[4:2])
            3'd0, 3'd1, 3'd2, 3'd3: base = DBASE;
            3'd4, 3'd5:             base = TBASE;
            3'd6:                   base = NBASE;
            default:                base = DBASE | TBASE;  // Memory wins.
        endcase
        req.sel   = (rnd[1:0] != 2'b00);
        req.we    = rnd[5];
        req.mask  = rnd[9:6];
        req.addr  = base + {24'd0, rnd[15:10], 2'b00};
        req.wdata = $random(seed);
        return req;
    endfunction

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: %s stayed high for %0d cycles", $time, what, TIMEOUT);
        $display("CHECKS FAILED");
        $finish;
    endtask

    // Each fetch holds its address until the stall falls.
    task automatic run_fetches();
        logic [31:0] rnd;
        int          waited;
        for (int n = 0; n < N_FETCH; n++) begin
            rnd         = $random(seed);
            ifetch_addr = IBASE + {24'd0, rnd[5:0], 2'b00};
            waited      = 0;
            @(posedge clk);
            while (ifetch_stall && waited < TIMEOUT) begin
                waited++;
                @(posedge clk);
            end
            if (ifetch_stall) begin
                report_timeout("ifetch_stall_o");
            end
            #1;
        end
    endtask

    task automatic run_data_accesses();
        int waited;
        for (int n = 0; n < N_DATA; n++) begin
            dbus_req = random_data_req();
            waited   = 0;
            @(posedge clk);
            while (dbus_stall && waited < TIMEOUT) begin
                waited++;
                @(posedge clk);
            end
            if (dbus_stall) begin
                report_timeout("dbus_stall_o");
            end
            #1;
        end
        dbus_req = '0;
    endtask

    // External memory, answers after 0 to 3 wait cycles.
    initial begin : memory_model
        int                 delay;
        logic               busy;
        logic [`MEM_DW-1:0] word;
        delay     = 0;
        busy      = 1'b0;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            if (mem_valid && mem_ready) begin
                word = read_mem(mem_addr);
                for (int b = 0; b < `MEM_SW; b++) begin
                    if (mem_wstrb[b]) begin
                        word[8*b +: 8] = mem_wdata[8*b +: 8];
                    end
                end
                ext_mem[mem_addr[`MEM_AW-1:`WORD_OFS_W]] = word;
                busy = 1'b0;
            end
            #1;
            mem_ready = 1'b0;
            if (rst_n && mem_valid && !busy) begin
                busy  = 1'b1;
                delay = $unsigned($random(seed)) % 4;
            end
            if (busy) begin
                if (delay == 0) begin
                    mem_ready = 1'b1;
                    mem_rdata = read_mem(mem_addr);
                end else begin
                    delay--;
                end
            end
        end
    end

    initial begin : stimulus
        rst_n       = 1'b0;
        ifetch_addr = IBASE;
        dbus_req    = '0;
        final_check = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fork
            run_fetches();
            run_data_accesses();
        join
        final_check = 1'b1;  // Transfer count is compared at the next edge.
        @(posedge clk);
        #1;
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- mem_subsys.f
+incdir+hw
hw/mem_subsys_pkg.sv
hw/icache.sv
hw/data_port.sv
hw/mem_arbiter.sv
hw/mem_subsys.sv
bench/mem_subsys_props.sv
bench/mem_subsys_checker.sv
bench/mem_subsys_tb.sv

//--- Makefile
# Verilator build and run for the memory subsystem testbench.

VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= mem_subsys.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
